//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := vcore_tb
FILELIST := vcore.f
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- common/vcore_pkg.sv
`default_nettype none

package vcore_pkg;

    // ============================================================
    // sizes
    // ============================================================

    localparam int lanes      = 4;
    localparam int elem_w     = 32;
    localparam int vec_w      = lanes * elem_w;
    localparam int reg_depth  = 32;
    localparam int reg_addr_w = $clog2(reg_depth);
    localparam int pc_w       = 8;
    localparam int mem_addr_w = 12;

    // ============================================================
    // opcodes and alu function codes
    // ============================================================

    localparam logic [3:0] op_nop    = 4'd0;
    localparam logic [3:0] op_valu   = 4'd1;
    localparam logic [3:0] op_vload  = 4'd2;
    localparam logic [3:0] op_vstore = 4'd3;
    localparam logic [3:0] op_jump   = 4'd4;
    localparam logic [3:0] op_branch = 4'd5;

    localparam logic [2:0] fn_add = 3'd0;
    localparam logic [2:0] fn_sub = 3'd1;
    localparam logic [2:0] fn_and = 3'd2;
    localparam logic [2:0] fn_or  = 3'd3;
    localparam logic [2:0] fn_xor = 3'd4;
    // low word of a * b + c
    localparam logic [2:0] fn_mac = 3'd5;
    // 1 or 0 per lane, slt compares signed
    localparam logic [2:0] fn_seq = 3'd6;
    localparam logic [2:0] fn_slt = 3'd7;

    // ============================================================
    // instruction formats
    // ============================================================

    typedef struct packed {
        logic [3:0]            opcode;
        logic [reg_addr_w-1:0] vd;
        logic [reg_addr_w-1:0] vs1;
        logic [reg_addr_w-1:0] vs2;
        logic [reg_addr_w-1:0] vs3;
        logic [2:0]            funct3;
        logic [4:0]            unused;
    } instr_r_t;

    // ra is vd for load, store source for store, vs1 for branch
    typedef struct packed {
        logic [3:0]            opcode;
        logic [reg_addr_w-1:0] ra;
        logic [reg_addr_w-1:0] rb;
        logic [5:0]            unused;
        logic [mem_addr_w-1:0] addr;
    } instr_m_t;

    typedef union packed {
        instr_r_t r;
        instr_m_t m;
    } instr_u;

endpackage

`default_nettype wire

//--- execute/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward import vcore_pkg::*; (
    input  logic [reg_addr_w-1:0] src1,
    input  logic [reg_addr_w-1:0] src2,
    input  logic [reg_addr_w-1:0] src3,
    input  logic [vec_w-1:0]      rf1,
    input  logic [vec_w-1:0]      rf2,
    input  logic [vec_w-1:0]      rf3,
    input  logic [reg_addr_w-1:0] ex2_vd,
    input  logic [reg_addr_w-1:0] wb_vd,
    input  logic                  ex2_we,
    input  logic                  wb_we,
    input  logic [vec_w-1:0]      ex2_data,
    input  logic [vec_w-1:0]      wb_data,
    output logic [vec_w-1:0]      opa,
    output logic [vec_w-1:0]      opb,
    output logic [vec_w-1:0]      opc
);

    // youngest producer wins: ex2, then wb, then the register file
    function automatic logic [vec_w-1:0] pick(
        input logic [reg_addr_w-1:0] src,
        input logic [vec_w-1:0]      rf
    );
        logic [vec_w-1:0] sel;
        if (ex2_we && ex2_vd == src) begin
            sel = ex2_data;
        end else if (wb_we && wb_vd == src) begin
            sel = wb_data;
        end else begin
            sel = rf;
        end
        return sel;
    endfunction

    always_comb begin
        opa = pick(src1, rf1);
        opb = pick(src2, rf2);
        opc = pick(src3, rf3);
    end

endmodule

`default_nettype wire

//--- execute/vector_alu.sv
`timescale 1ns/1ps
`default_nettype none

module vector_alu import vcore_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en,
    input  logic [2:0]       funct3,
    input  logic [vec_w-1:0] opa,
    input  logic [vec_w-1:0] opb,
    input  logic [vec_w-1:0] opc,
    output logic [vec_w-1:0] result
);

    logic [vec_w-1:0] result_d;

    always_comb begin
        logic [elem_w-1:0] a;
        logic [elem_w-1:0] b;
        logic [elem_w-1:0] c;
        logic [elem_w-1:0] y;

        result_d = '0;
        for (int i = 0; i < lanes; i++) begin
            a = opa[i*elem_w +: elem_w];
            b = opb[i*elem_w +: elem_w];
            c = opc[i*elem_w +: elem_w];
            case (funct3)
                fn_add:  y = a + b;
                fn_sub:  y = a - b;
                fn_and:  y = a & b;
                fn_or:   y = a | b;
                fn_xor:  y = a ^ b;
                // only the low word of the product is kept
                fn_mac:  y = a * b + c;
                fn_seq:  y = elem_w'(a == b);
                fn_slt:  y = elem_w'($signed(a) < $signed(b));
                default: y = '0;
            endcase
            result_d[i*elem_w +: elem_w] = y;
        end
    end

    // one cycle latency, ex1 to ex2
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
        end else if (en) begin
            result <= result_d;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) en |-> !$isunknown(funct3))
        else $error("alu function code unknown while the pipeline advances");

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import vcore_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    input  logic            jump,
    input  logic [pc_w-1:0] jump_addr,
    input  logic            branch,
    input  logic [pc_w-1:0] branch_addr,
    output logic [pc_w-1:0] pc
);

    // branch sits in ex2 and is older than a jump in id
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (en) begin
            if (branch) begin
                pc <= branch_addr;
            end else if (jump) begin
                pc <= jump_addr;
            end else begin
                pc <= pc + pc_w'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import vcore_pkg::*; (
    input  instr_u                instr,
    output logic [reg_addr_w-1:0] vd,
    output logic [reg_addr_w-1:0] vs1,
    output logic [reg_addr_w-1:0] vs2,
    output logic [reg_addr_w-1:0] vs3,
    output logic [mem_addr_w-1:0] mem_addr,
    output logic [2:0]            funct3,
    output logic                  reg_we,
    output logic                  mem_rd,
    output logic                  mem_we,
    output logic                  jump,
    output logic                  branch
);

    // address field is common to load, store, jump and branch
    assign mem_addr = instr.m.addr;

    always_comb begin
        vd     = '0;
        vs1    = '0;
        vs2    = '0;
        vs3    = '0;
        funct3 = fn_add;
        reg_we = 1'b0;
        mem_rd = 1'b0;
        mem_we = 1'b0;
        jump   = 1'b0;
        branch = 1'b0;

        case (instr.r.opcode)
            op_valu: begin
                vd     = instr.r.vd;
                vs1    = instr.r.vs1;
                vs2    = instr.r.vs2;
                vs3    = instr.r.vs3;
                funct3 = instr.r.funct3;
                reg_we = 1'b1;
            end
            op_vload: begin
                vd     = instr.m.ra;
                reg_we = 1'b1;
                mem_rd = 1'b1;
            end
            op_vstore: begin
                // store data leaves through operand c
                vs3    = instr.m.ra;
                mem_we = 1'b1;
            end
            op_jump: begin
                jump = 1'b1;
            end
            op_branch: begin
                // compare is done by the alu as set-equal
                vs1    = instr.m.ra;
                vs2    = instr.m.rb;
                funct3 = fn_seq;
                branch = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/vcore_top.sv
`timescale 1ns/1ps
`default_nettype none

module vcore_top import vcore_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    output logic [pc_w-1:0]       pc,
    input  instr_u                instr,
    output logic [mem_addr_w-1:0] mem_addr,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic [vec_w-1:0]      mem_wdata,
    input  logic [vec_w-1:0]      mem_rdata,
    output logic                  data_out_vld,
    output logic [vec_w-1:0]      data_out,
    output logic [reg_addr_w-1:0] reg_wb
);

    // id stage
    logic [reg_addr_w-1:0] vd_id;
    logic [reg_addr_w-1:0] vs1_id;
    logic [reg_addr_w-1:0] vs2_id;
    logic [reg_addr_w-1:0] vs3_id;
    logic [mem_addr_w-1:0] addr_id;
    logic [2:0]            funct3_id;
    logic                  reg_we_id;
    logic                  mem_rd_id;
    logic                  mem_we_id;
    logic                  jump_id;
    logic                  branch_id;
    logic [vec_w-1:0]      rf1_id;
    logic [vec_w-1:0]      rf2_id;
    logic [vec_w-1:0]      rf3_id;

    // ex1 stage
    logic [reg_addr_w-1:0] vd_ex1;
    logic [reg_addr_w-1:0] vs1_ex1;
    logic [reg_addr_w-1:0] vs2_ex1;
    logic [reg_addr_w-1:0] vs3_ex1;
    logic [mem_addr_w-1:0] addr_ex1;
    logic [2:0]            funct3_ex1;
    logic                  reg_we_ex1;
    logic                  mem_rd_ex1;
    logic                  mem_we_ex1;
    logic                  branch_ex1;
    logic [vec_w-1:0]      rf1_ex1;
    logic [vec_w-1:0]      rf2_ex1;
    logic [vec_w-1:0]      rf3_ex1;
    logic [vec_w-1:0]      opa;
    logic [vec_w-1:0]      opb;
    logic [vec_w-1:0]      opc;

    // ex2 and wb stages
    logic [reg_addr_w-1:0] vd_ex2;
    logic                  reg_we_ex2;
    logic                  load_ex2;
    logic                  branch_ex2;
    logic [pc_w-1:0]       target_ex2;
    logic [vec_w-1:0]      alu_ex2;
    logic [vec_w-1:0]      data_ex2;
    logic                  branch_taken;
    logic [reg_addr_w-1:0] vd_wb;
    logic                  reg_we_wb;
    logic [vec_w-1:0]      data_wb;

    // ============================================================
    // fetch and decode
    // ============================================================

    fetch_unit i_fetch_unit (
        .clk         (clk                    ),
        .rst_n       (rst_n                  ),
        .en          (en                     ),
        .jump        (jump_id                ),
        .jump_addr   (addr_id[pc_w-1:0]      ),
        .branch      (branch_taken           ),
        .branch_addr (target_ex2             ),
        .pc          (pc                     )
    );

    instr_decoder i_instr_decoder (
        .instr    (instr     ),
        .vd       (vd_id     ),
        .vs1      (vs1_id    ),
        .vs2      (vs2_id    ),
        .vs3      (vs3_id    ),
        .mem_addr (addr_id   ),
        .funct3   (funct3_id ),
        .reg_we   (reg_we_id ),
        .mem_rd   (mem_rd_id ),
        .mem_we   (mem_we_id ),
        .jump     (jump_id   ),
        .branch   (branch_id )
    );

    vector_regfile i_vector_regfile (
        .clk    (clk              ),
        .rst_n  (rst_n            ),
        .we     (en && reg_we_wb  ),
        .waddr  (vd_wb            ),
        .wdata  (data_wb          ),
        .raddr1 (vs1_id           ),
        .raddr2 (vs2_id           ),
        .raddr3 (vs3_id           ),
        .rdata1 (rf1_id           ),
        .rdata2 (rf2_id           ),
        .rdata3 (rf3_id           )
    );

    // ============================================================
    // execute
    // ============================================================

    operand_forward i_operand_forward (
        .src1     (vs1_ex1    ),
        .src2     (vs2_ex1    ),
        .src3     (vs3_ex1    ),
        .rf1      (rf1_ex1    ),
        .rf2      (rf2_ex1    ),
        .rf3      (rf3_ex1    ),
        .ex2_vd   (vd_ex2     ),
        .wb_vd    (vd_wb      ),
        .ex2_we   (reg_we_ex2 ),
        .wb_we    (reg_we_wb  ),
        .ex2_data (data_ex2   ),
        .wb_data  (data_wb    ),
        .opa      (opa        ),
        .opb      (opb        ),
        .opc      (opc        )
    );

    vector_alu i_vector_alu (
        .clk    (clk        ),
        .rst_n  (rst_n      ),
        .en     (en         ),
        .funct3 (funct3_ex1 ),
        .opa    (opa        ),
        .opb    (opb        ),
        .opc    (opc        ),
        .result (alu_ex2    )
    );

    // memory request goes out from ex1, data comes back in ex2
    assign mem_addr  = addr_ex1;
    assign mem_read  = en && mem_rd_ex1;
    assign mem_write = en && mem_we_ex1;
    assign mem_wdata = opc;

    assign data_ex2     = load_ex2 ? mem_rdata : alu_ex2;
    // branch decides on lane 0 of the set-equal result
    assign branch_taken = branch_ex2 && alu_ex2[0];

    // ============================================================
    // writeback
    // ============================================================

    assign data_out_vld = en && reg_we_wb;
    assign data_out     = data_wb;
    assign reg_wb       = vd_wb;

    // ============================================================
    // pipeline registers
    // ============================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vd_ex1     <= '0;
            vs1_ex1    <= '0;
            vs2_ex1    <= '0;
            vs3_ex1    <= '0;
            addr_ex1   <= '0;
            funct3_ex1 <= fn_add;
            reg_we_ex1 <= 1'b0;
            mem_rd_ex1 <= 1'b0;
            mem_we_ex1 <= 1'b0;
            branch_ex1 <= 1'b0;
            rf1_ex1    <= '0;
            rf2_ex1    <= '0;
            rf3_ex1    <= '0;
            vd_ex2     <= '0;
            reg_we_ex2 <= 1'b0;
            load_ex2   <= 1'b0;
            branch_ex2 <= 1'b0;
            target_ex2 <= '0;
            vd_wb      <= '0;
            reg_we_wb  <= 1'b0;
            data_wb    <= '0;
        end else if (en) begin
            vd_ex1     <= vd_id;
            vs1_ex1    <= vs1_id;
            vs2_ex1    <= vs2_id;
            vs3_ex1    <= vs3_id;
            addr_ex1   <= addr_id;
            funct3_ex1 <= funct3_id;
            reg_we_ex1 <= reg_we_id;
            mem_rd_ex1 <= mem_rd_id;
            mem_we_ex1 <= mem_we_id;
            branch_ex1 <= branch_id;
            rf1_ex1    <= rf1_id;
            rf2_ex1    <= rf2_id;
            rf3_ex1    <= rf3_id;

            vd_ex2     <= vd_ex1;
            reg_we_ex2 <= reg_we_ex1;
            load_ex2   <= mem_rd_ex1;
            branch_ex2 <= branch_ex1;
            target_ex2 <= addr_ex1[pc_w-1:0];

            vd_wb      <= vd_ex2;
            reg_we_wb  <= reg_we_ex2;
            data_wb    <= data_ex2;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(mem_read && mem_write))
        else $error("load and store requested in the same cycle");

endmodule

`default_nettype wire

//--- hw/vector_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module vector_regfile import vcore_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [vec_w-1:0]      wdata,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  logic [reg_addr_w-1:0] raddr3,
    output logic [vec_w-1:0]      rdata1,
    output logic [vec_w-1:0]      rdata2,
    output logic [vec_w-1:0]      rdata3
);

    logic [vec_w-1:0] regs [reg_depth];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_depth; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through, a read in the writing cycle sees the new vector
    assign rdata1 = (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (we && waddr == raddr2) ? wdata : regs[raddr2];
    assign rdata3 = (we && waddr == raddr3) ? wdata : regs[raddr3];

endmodule

`default_nettype wire

//--- testbench/vcore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vcore_tb import vcore_pkg::*; ();

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  en;
    logic [pc_w-1:0]       pc;
    instr_u                instr;
    logic [mem_addr_w-1:0] mem_addr;
    logic                  mem_read;
    logic                  mem_write;
    logic [vec_w-1:0]      mem_wdata;
    logic [vec_w-1:0]      mem_rdata;
    logic                  data_out_vld;
    logic [vec_w-1:0]      data_out;
    logic [reg_addr_w-1:0] reg_wb;

    instr_u                rom [1 << pc_w];
    logic [vec_w-1:0]      data_mem [1 << mem_addr_w];
    logic [vec_w-1:0]      ref_mem [1 << mem_addr_w];
    logic [vec_w-1:0]      ref_regs [reg_depth];
    logic [reg_addr_w-1:0] exp_wb_reg [$];
    logic [vec_w-1:0]      exp_wb_vec [$];
    logic [mem_addr_w-1:0] exp_st_addr [$];
    logic [vec_w-1:0]      exp_st_vec [$];
    int                    prog_len;
    int                    timeout_cycles;
    int                    cycles;

    always #2 clk = ~clk;

    vcore_top i_vcore_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .pc           (pc),
        .instr        (instr),
        .mem_addr     (mem_addr),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .data_out_vld (data_out_vld),
        .data_out     (data_out),
        .reg_wb       (reg_wb)
    );

    // ============================================================
    // instruction rom and data memory
    // ============================================================

    assign instr = rom[pc];

    // read data shows up one edge after the request
    always @(posedge clk) begin
        if (mem_write) begin
            data_mem[mem_addr] <= mem_wdata;
        end
        if (mem_read) begin
            mem_rdata <= #1 data_mem[mem_addr];
        end
    end

    // every lane carries the full address, lane 0 never zero
    function automatic logic [vec_w-1:0] mem_fill(input int addr);
        logic [vec_w-1:0] v;
        for (int l = 0; l < lanes; l++) begin
            v[l*elem_w +: elem_w] = {4'ha, 12'(addr), 4'(l), 12'(addr) ^ 12'h5a5};
        end
        return v;
    endfunction

    // ============================================================
    // program
    // ============================================================

    function automatic instr_u alu_instr(input logic [2:0] f, input logic [reg_addr_w-1:0] vd,
                                         input logic [reg_addr_w-1:0] vs1,
                                         input logic [reg_addr_w-1:0] vs2,
                                         input logic [reg_addr_w-1:0] vs3);
        instr_u u;
        u.r.opcode = op_valu;
        u.r.vd     = vd;
        u.r.vs1    = vs1;
        u.r.vs2    = vs2;
        u.r.vs3    = vs3;
        u.r.funct3 = f;
        u.r.unused = '0;
        return u;
    endfunction

    function automatic instr_u mem_instr(input logic [3:0] op, input logic [reg_addr_w-1:0] ra,
                                         input logic [reg_addr_w-1:0] rb,
                                         input logic [mem_addr_w-1:0] addr);
        instr_u u;
        u.m.opcode = op;
        u.m.ra     = ra;
        u.m.rb     = rb;
        u.m.unused = '0;
        u.m.addr   = addr;
        return u;
    endfunction

    task automatic append_instr(input instr_u u);
        rom[pc_w'(prog_len)] = u;
        prog_len++;
    endtask

    task automatic load_program();
        logic [2:0]            f;
        logic [reg_addr_w-1:0] d;
        logic [reg_addr_w-1:0] s1;
        logic [reg_addr_w-1:0] s2;
        logic [reg_addr_w-1:0] s3;
        for (int i = 0; i < (1 << pc_w); i++) begin
            rom[i] = mem_instr(op_nop, 0, 0, 12'h000);
        end
        prog_len = 0;
        // v20 and v21 were never written
        append_instr(alu_instr(fn_add, 1, 20, 21, 0));
        append_instr(mem_instr(op_vload, 2, 0, 12'h010));
        append_instr(alu_instr(fn_add, 3, 2, 2, 0));
        append_instr(mem_instr(op_vload, 4, 0, 12'h123));
        append_instr(alu_instr(fn_sub, 5, 4, 2, 0));
        append_instr(alu_instr(fn_and, 6, 5, 3, 0));
        append_instr(alu_instr(fn_or, 7, 6, 4, 0));
        append_instr(alu_instr(fn_xor, 8, 7, 5, 0));
        append_instr(alu_instr(fn_mac, 9, 8, 7, 6));
        append_instr(alu_instr(fn_seq, 10, 9, 9, 0));
        append_instr(alu_instr(fn_slt, 11, 5, 10, 0));
        append_instr(mem_instr(op_vstore, 9, 0, 12'h200));
        append_instr(mem_instr(op_vstore, 11, 0, 12'h201));
        append_instr(mem_instr(op_vload, 12, 0, 12'h200));
        // store source comes straight from the load
        append_instr(mem_instr(op_vstore, 12, 0, 12'h202));
        append_instr(mem_instr(op_jump, 0, 0, 12'd18));
        append_instr(alu_instr(fn_add, 13, 3, 3, 0));
        append_instr(mem_instr(op_vstore, 13, 0, 12'h300));
        // taken, slots at 19 and 20
        append_instr(mem_instr(op_branch, 10, 10, 12'd23));
        append_instr(alu_instr(fn_add, 14, 2, 9, 0));
        append_instr(alu_instr(fn_xor, 15, 14, 3, 0));
        append_instr(alu_instr(fn_add, 16, 1, 2, 0));
        append_instr(mem_instr(op_vstore, 16, 0, 12'h301));
        // not taken, v1 is zero
        append_instr(mem_instr(op_branch, 2, 1, 12'd30));
        append_instr(alu_instr(fn_add, 17, 15, 14, 0));
        append_instr(alu_instr(fn_mac, 18, 17, 4, 17));
        append_instr(mem_instr(op_vstore, 18, 0, 12'h3ff));
        for (int i = 0; i < 40; i++) begin
            f  = 3'($urandom);
            d  = reg_addr_w'($urandom);
            s1 = reg_addr_w'($urandom);
            s2 = reg_addr_w'($urandom);
            s3 = reg_addr_w'($urandom);
            append_instr(alu_instr(f, d, s1, s2, s3));
        end
    endtask

    // ============================================================
    // reference model
    // ============================================================

    function automatic logic [elem_w-1:0] lane_result(input logic [2:0] f,
                                                      input logic [elem_w-1:0] a,
                                                      input logic [elem_w-1:0] b,
                                                      input logic [elem_w-1:0] c);
        case (f)
            fn_add:  return a + b;
            fn_sub:  return a - b;
            fn_and:  return a & b;
            fn_or:   return a | b;
            fn_xor:  return a ^ b;
            fn_mac:  return a * b + c;
            fn_seq:  return (a == b) ? elem_w'(1) : '0;
            default: return ($signed(a) < $signed(b)) ? elem_w'(1) : '0;
        endcase
    endfunction

    function automatic logic [vec_w-1:0] alu_vector(input logic [2:0] f,
                                                    input logic [vec_w-1:0] a,
                                                    input logic [vec_w-1:0] b,
                                                    input logic [vec_w-1:0] c);
        logic [vec_w-1:0] y;
        for (int l = 0; l < lanes; l++) begin
            y[l*elem_w +: elem_w] = lane_result(f, a[l*elem_w +: elem_w],
                                                b[l*elem_w +: elem_w], c[l*elem_w +: elem_w]);
        end
        return y;
    endfunction

    // in-order model, a taken branch redirects after two more instructions
    function automatic void build_expected();
        logic [pc_w-1:0]  pc_m;
        logic [pc_w-1:0]  next_pc;
        logic [pc_w-1:0]  tgt;
        logic [vec_w-1:0] y;
        instr_u           ins;
        int               slots;
        int               n;
        pc_m  = '0;
        tgt   = '0;
        slots = 0;
        n     = 0;
        for (int i = 0; i < reg_depth; i++) begin
            ref_regs[i] = '0;
        end
        while ((int'(pc_m) < prog_len || slots > 0) && n < 4 * prog_len) begin
            ins     = rom[pc_m];
            next_pc = pc_m + pc_w'(1);
            case (ins.r.opcode)
                op_valu: begin
                    y = alu_vector(ins.r.funct3, ref_regs[ins.r.vs1], ref_regs[ins.r.vs2],
                                   ref_regs[ins.r.vs3]);
                    ref_regs[ins.r.vd] = y;
                    exp_wb_reg.push_back(ins.r.vd);
                    exp_wb_vec.push_back(y);
                end
                op_vload: begin
                    ref_regs[ins.m.ra] = ref_mem[ins.m.addr];
                    exp_wb_reg.push_back(ins.m.ra);
                    exp_wb_vec.push_back(ref_mem[ins.m.addr]);
                end
                op_vstore: begin
                    ref_mem[ins.m.addr] = ref_regs[ins.m.ra];
                    exp_st_addr.push_back(ins.m.addr);
                    exp_st_vec.push_back(ref_regs[ins.m.ra]);
                end
                op_jump: next_pc = ins.m.addr[pc_w-1:0];
                default: ;
            endcase
            if (slots > 0) begin
                slots--;
                if (slots == 0) begin
                    next_pc = tgt;
                end
            end
            if (ins.m.opcode == op_branch &&
                ref_regs[ins.m.ra][elem_w-1:0] == ref_regs[ins.m.rb][elem_w-1:0]) begin
                slots = 2;
                tgt   = ins.m.addr[pc_w-1:0];
            end
            pc_m = next_pc;
            n++;
        end
    endfunction

    // ============================================================
    // checks
    // ============================================================

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_vec(input string name, input logic [vec_w-1:0] got,
                             input logic [vec_w-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input logic [reg_addr_w-1:0] got,
                             input logic [reg_addr_w-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [mem_addr_w-1:0] got,
                              input logic [mem_addr_w-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (!en && (data_out_vld || mem_read || mem_write)) begin
                $display("a strobe was raised while en was low at %0t", $time);
                abort_run();
            end
            if (data_out_vld) begin
                if (exp_wb_reg.size() == 0) begin
                    $display("writeback to v%0d at %0t was not expected", reg_wb, $time);
                    abort_run();
                end else begin
                    check_reg("reg_wb", reg_wb, exp_wb_reg.pop_front());
                    check_vec("data_out", data_out, exp_wb_vec.pop_front());
                end
            end
            if (mem_write) begin
                if (exp_st_addr.size() == 0) begin
                    $display("store to %h at %0t was not expected", mem_addr, $time);
                    abort_run();
                end else begin
                    check_addr("mem_addr", mem_addr, exp_st_addr.pop_front());
                    check_vec("mem_wdata", mem_wdata, exp_st_vec.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_cycles) begin
            $display("program did not finish within %0d cycles", timeout_cycles);
            abort_run();
        end
    end

    initial begin
        rst_n     = 1'b0;
        en        = 1'b1;
        mem_rdata = '0;
        cycles    = 0;
        void'($urandom(32'h400f_58fb));
        for (int i = 0; i < (1 << mem_addr_w); i++) begin
            data_mem[i] = mem_fill(i);
            ref_mem[i]  = mem_fill(i);
        end
        load_program();
        build_expected();
        timeout_cycles = 4 * prog_len + 50;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        // freeze in the middle of the directed section
        repeat (20) @(posedge clk);
        #1 en = 1'b0;
        repeat (6) @(posedge clk);
        #1 en = 1'b1;
        while (exp_wb_reg.size() != 0 || exp_st_addr.size() != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vcore.f
common/vcore_pkg.sv
hw/fetch_unit.sv
hw/instr_decoder.sv
hw/vector_regfile.sv
execute/operand_forward.sv
execute/vector_alu.sv
hw/vcore_top.sv
testbench/vcore_tb.sv
